//--- sources.f
+incdir+tests
design/robot_pkg.sv
design/mode_fsm.sv
design/drive_timer.sv
design/drive_select.sv
design/motor_pwm.sv
design/robot_drive_top.sv
tests/robot_drive_tb.sv

//--- Bender.yml
package:
  name: robot_drive

sources:
  - files:
      - design/robot_pkg.sv
      - design/mode_fsm.sv
      - design/drive_timer.sv
      - design/drive_select.sv
      - design/motor_pwm.sv
      - design/robot_drive_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/robot_drive_tb.sv

//--- tests/robot_drive_model.svh
`ifndef ROBOT_DRIVE_MODEL_SVH
`define ROBOT_DRIVE_MODEL_SVH

// reference state, stepped once per rising clock edge
mode_t      m_mode;
cam_state_t m_cam;
logic       m_change;
drive_t     m_manual;
int         m_hold;
drive_t     m_drive;

task automatic model_reset();
    m_mode   = mode_idle;
    m_cam    = cam_pause;
    m_change = 1'b0;
    m_manual = drive_stop;
    m_hold   = 0;
    m_drive  = drive_stop;
endtask

// steering while following the target
function automatic drive_t follow_model(input sensor_t s);
    if (s.direction == cam_dir_right)
        return drive_right;
    if (s.direction == cam_dir_left)
        return drive_left;
    if (s.direction != cam_dir_ahead)
        return drive_stop;
    case (s.speed)
        2'd0:    return drive_slow;
        2'd1:    return drive_medium;
        2'd2:    return drive_fast;
        default: return drive_stop;
    endcase
endfunction

// inputs are the values sampled at this edge
task automatic model_step(input logic valid, input logic [7:0] code, input sensor_t s);
    mode_t      mode_nx;
    cam_state_t cam_nx;
    logic       load;
    drive_t     drive_nx;
    mode_nx = m_mode;
    if (valid) begin
        if (m_mode != mode_cam && code == btn_cam)
            mode_nx = mode_cam;
        else if (m_mode != mode_ir && code == btn_ir)
            mode_nx = mode_ir;
        else if (m_mode != mode_idle && code == btn_idle)
            mode_nx = mode_idle;
    end
    if (mode_nx != mode_cam)
        cam_nx = cam_pause;
    else if (m_cam == cam_pause)
        cam_nx = cam_search;
    else
        cam_nx = s.orange ? cam_follow : cam_search;
    load = valid && (m_mode == mode_ir)
        && (code inside {btn_fwd, btn_left, btn_right, btn_stop});
    // drive uses the registered mode and hold, one edge behind
    drive_nx = drive_stop;
    if (m_mode == mode_cam && m_cam == cam_search)
        drive_nx = drive_right;
    else if (m_mode == mode_cam && m_cam == cam_follow)
        drive_nx = follow_model(s);
    else if (m_mode == mode_ir && m_hold != 0)
        drive_nx = m_manual;
    if (load)
        m_hold = hold_ticks;
    else if (m_change)
        m_hold = 0;
    else if (m_hold > 0)
        m_hold = m_hold - 1;
    if (load) begin
        case (code)
            btn_fwd:   m_manual = drive_medium;
            btn_left:  m_manual = drive_left;
            btn_right: m_manual = drive_right;
            default:   m_manual = drive_stop;
        endcase
    end
    m_change = (mode_nx != m_mode) || (cam_nx != m_cam);
    m_mode   = mode_nx;
    m_cam    = cam_nx;
    m_drive  = drive_nx;
endtask

`endif

//--- tests/robot_drive_tb.sv
`timescale 1ns/1ps

module robot_drive_tb import robot_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int run_cycles   = 6000;

    logic       clk_50;
    logic       rst_n;
    logic       ir_valid;
    logic [7:0] ir_code;
    sensor_t    sensor;
    mode_t      mode;
    cam_state_t cam_state;
    drive_t     drive;
    motor_cmd_t motor;
    logic       mode_change;

    integer     seed = 20759;
    logic [7:0] button_codes [7] = '{btn_cam, btn_ir, btn_idle, btn_fwd,
                                     btn_left, btn_right, btn_stop};

    // pwm window bookkeeping
    drive_t last_drive;
    drive_t win_drive;
    int     win_len;
    int     left_high;
    int     right_high;

    `include "robot_drive_model.svh"

    robot_drive_top robot_drive_top_i (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .ir_valid    (ir_valid),
        .ir_code     (ir_code),
        .sensor      (sensor),
        .mode        (mode),
        .cam_state   (cam_state),
        .drive       (drive),
        .motor       (motor),
        .mode_change (mode_change)
    );

    always #(clk_period / 2) clk_50 = ~clk_50;

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic int duty_of(input drive_t d);
        case (d)
            drive_left, drive_right: return duty_turn;
            drive_slow:              return duty_slow;
            drive_medium:            return duty_medium;
            drive_fast:              return duty_fast;
            default:                 return 0;
        endcase
    endfunction

    // motor reflects the drive from one cycle back
    task automatic check_motor();
        compare_value("motor.left_fwd", last_drive != drive_left, motor.left_fwd);
        compare_value("motor.right_fwd", last_drive != drive_right, motor.right_fwd);
        if (last_drive != win_drive) begin
            win_drive  = last_drive;
            win_len    = 0;
            left_high  = 0;
            right_high = 0;
        end
        win_len    = win_len + 1;
        left_high  = left_high + motor.left_pwm;
        right_high = right_high + motor.right_pwm;
        // any pwm_period consecutive cycles cover every count once
        if (win_len == pwm_period) begin
            compare_value("left_pwm high cycles", duty_of(win_drive), left_high);
            compare_value("right_pwm high cycles", duty_of(win_drive), right_high);
            win_len    = 0;
            left_high  = 0;
            right_high = 0;
        end
    endtask

    task automatic drive_inputs(input int cycle);
        logic quiet;
        int   strobe_rate;
        int   sensor_rate;
        int   pick;
        // a quiet stretch now and then lets manual holds run out and the camera report settle
        quiet       = (cycle % 1500 >= 1200);
        strobe_rate = quiet ? 97 : 12;
        sensor_rate = quiet ? 60 : 4;
        ir_valid = 1'b0;
        ir_code  = 8'($random(seed));
        if ({$random(seed)} % strobe_rate == 0) begin
            pick     = {$random(seed)} % 9;
            ir_valid = 1'b1;
            if (pick < 7)
                ir_code = button_codes[pick];
        end
        if ({$random(seed)} % sensor_rate == 0) begin
            sensor = 6'($random(seed));
            // target straight ahead most of the time, so follow mode reaches every speed
            if ({$random(seed)} % 4 != 0) begin
                sensor.direction = cam_dir_ahead;
                sensor.orange    = 1'b1;
            end
        end
    endtask

    initial begin
        clk_50   = 1'b0;
        rst_n    = 1'b0;
        ir_valid = 1'b0;
        ir_code  = 8'h00;
        sensor   = '0;
        model_reset();
        last_drive = drive_stop;
        win_drive  = drive_stop;
        win_len    = 0;
        left_high  = 0;
        right_high = 0;
        repeat (reset_cycles) @(posedge clk_50);
        #1;
        compare_value("mode", mode_idle, mode);
        compare_value("cam_state", cam_pause, cam_state);
        compare_value("drive", drive_stop, drive);
        compare_value("motor", 8'h00, motor);
        compare_value("mode_change", 1'b0, mode_change);
        rst_n = 1'b1;
        for (int cycle = 0; cycle < run_cycles; cycle++) begin
            @(posedge clk_50);
            model_step(ir_valid, ir_code, sensor);
            #1;
            compare_value("mode", m_mode, mode);
            compare_value("cam_state", m_cam, cam_state);
            compare_value("drive", m_drive, drive);
            compare_value("mode_change", m_change, mode_change);
            check_motor();
            last_drive = m_drive;
            drive_inputs(cycle);
        end
        $display("test passed");
        $finish;
    end

    initial begin
        #((run_cycles + reset_cycles + 100) * clk_period);
        $display("watchdog expired, the run did not finish in time");
        $display("test failed");
        $fatal(1);
    end

endmodule

//--- design/robot_drive_top.sv
`timescale 1ns/1ps

module robot_drive_top import robot_pkg::*; (
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       ir_valid,
    input  logic [7:0] ir_code,
    input  sensor_t    sensor,
    output mode_t      mode,
    output cam_state_t cam_state,
    output drive_t     drive,
    output motor_cmd_t motor,
    output logic       mode_change
);

    logic [pwm_count_w-1:0] pwm_count;
    logic                   hold_active;
    logic                   manual_load;

    mode_fsm mode_fsm_i (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .ir_valid    (ir_valid),
        .ir_code     (ir_code),
        .orange      (sensor.orange),
        .mode        (mode),
        .cam_state   (cam_state),
        .mode_change (mode_change)
    );

    drive_timer drive_timer_i (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .manual_load (manual_load),
        .mode_change (mode_change),
        .pwm_count   (pwm_count),
        .hold_active (hold_active)
    );

    drive_select drive_select_i (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .mode        (mode),
        .cam_state   (cam_state),
        .sensor      (sensor),
        .ir_valid    (ir_valid),
        .ir_code     (ir_code),
        .hold_active (hold_active),
        .drive       (drive),
        .manual_load (manual_load)
    );

    motor_pwm motor_pwm_i (
        .clk_50    (clk_50),
        .rst_n     (rst_n),
        .drive     (drive),
        .pwm_count (pwm_count),
        .motor     (motor)
    );

endmodule

//--- design/motor_pwm.sv
`timescale 1ns/1ps

module motor_pwm import robot_pkg::*; (
    input  logic                   clk_50,
    input  logic                   rst_n,
    input  drive_t                 drive,
    input  logic [pwm_count_w-1:0] pwm_count,
    output motor_cmd_t             motor
);

    logic [pwm_count_w-1:0] duty;
    logic                   left_fwd;
    logic                   right_fwd;

    // duty and wheel directions per drive state
    always_comb begin
        duty      = '0;
        left_fwd  = 1'b1;
        right_fwd = 1'b1;
        case (drive)
            drive_left: begin
                duty     = duty_turn;
                left_fwd = 1'b0;
            end
            drive_right: begin
                duty      = duty_turn;
                right_fwd = 1'b0;
            end
            drive_slow:   duty = duty_slow;
            drive_medium: duty = duty_medium;
            drive_fast:   duty = duty_fast;
            default:      duty = '0;
        endcase
    end

    // both wheels share one duty, turning comes from the direction bits
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            motor <= '0;
        end else begin
            motor.left_pwm  <= (pwm_count < duty);
            motor.right_pwm <= (pwm_count < duty);
            motor.left_fwd  <= left_fwd;
            motor.right_fwd <= right_fwd;
        end
    end

    a_stop_quiet : assert property (
        @(posedge clk_50) disable iff (!rst_n)
        ($past(drive) == drive_stop) |-> !motor.left_pwm && !motor.right_pwm
    );

endmodule

//--- design/drive_select.sv
`timescale 1ns/1ps

module drive_select import robot_pkg::*; (
    input  logic       clk_50,
    input  logic       rst_n,
    input  mode_t      mode,
    input  cam_state_t cam_state,
    input  sensor_t    sensor,
    input  logic       ir_valid,
    input  logic [7:0] ir_code,
    input  logic       hold_active,
    output drive_t     drive,
    output logic       manual_load
);

    drive_t manual_next;
    drive_t manual_drive;
    logic   manual_hit;
    drive_t follow_drive;

    // manual buttons, decoded whatever the mode
    always_comb begin
        manual_hit  = 1'b1;
        manual_next = drive_stop;
        case (ir_code)
            btn_fwd:   manual_next = drive_medium;
            btn_left:  manual_next = drive_left;
            btn_right: manual_next = drive_right;
            btn_stop:  manual_next = drive_stop;
            default:   manual_hit  = 1'b0;
        endcase
    end

    // only acted on while in IR mode
    assign manual_load = ir_valid && (mode == mode_ir) && manual_hit;

    always_ff @(posedge clk_50) begin
        if (manual_load)
            manual_drive <= manual_next;
    end

    // steering from the camera report while following
    always_comb begin
        case (sensor.direction)
            cam_dir_right: follow_drive = drive_right;
            cam_dir_left:  follow_drive = drive_left;
            cam_dir_ahead: begin
                case (sensor.speed)
                    2'd0:    follow_drive = drive_slow;
                    2'd1:    follow_drive = drive_medium;
                    2'd2:    follow_drive = drive_fast;
                    default: follow_drive = drive_stop;
                endcase
            end
            default: follow_drive = drive_stop;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            drive <= drive_stop;
        end else begin
            case (mode)
                mode_cam: begin
                    if (cam_state == cam_search)
                        drive <= drive_right;
                    else if (cam_state == cam_follow)
                        drive <= follow_drive;
                    else
                        drive <= drive_stop;
                end
                mode_ir: drive <= hold_active ? manual_drive : drive_stop;
                default: drive <= drive_stop;
            endcase
        end
    end

endmodule

//--- design/drive_timer.sv
`timescale 1ns/1ps

module drive_timer import robot_pkg::*; (
    input  logic                   clk_50,
    input  logic                   rst_n,
    input  logic                   manual_load,
    input  logic                   mode_change,
    output logic [pwm_count_w-1:0] pwm_count,
    output logic                   hold_active
);

    logic [hold_w-1:0] hold_count;

    // free-running pwm period counter
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            pwm_count <= '0;
        end else if (pwm_count == pwm_period - 1'b1) begin
            pwm_count <= '0;
        end else begin
            pwm_count <= pwm_count + 1'b1;
        end
    end

    // a fresh press wins over the clear, it can land right after entering IR mode
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            hold_count <= '0;
        end else if (manual_load) begin
            hold_count <= hold_ticks;
        end else if (mode_change) begin
            hold_count <= '0;
        end else if (hold_count != '0) begin
            hold_count <= hold_count - 1'b1;
        end
    end

    assign hold_active = (hold_count != '0);

    a_pwm_range : assert property (
        @(posedge clk_50) disable iff (!rst_n)
        pwm_count < pwm_period
    );

endmodule

//--- design/mode_fsm.sv
`timescale 1ns/1ps

module mode_fsm import robot_pkg::*; (
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       ir_valid,
    input  logic [7:0] ir_code,
    input  logic       orange,
    output mode_t      mode,
    output cam_state_t cam_state,
    output logic       mode_change
);

    mode_t      mode_next;
    cam_state_t cam_next;

    // mode only moves on a button strobe
    always_comb begin
        mode_next = mode;
        if (ir_valid) begin
            case (mode)
                mode_idle: begin
                    if (ir_code == btn_cam)
                        mode_next = mode_cam;
                    else if (ir_code == btn_ir)
                        mode_next = mode_ir;
                end
                mode_cam: begin
                    if (ir_code == btn_ir)
                        mode_next = mode_ir;
                    else if (ir_code == btn_idle)
                        mode_next = mode_idle;
                end
                mode_ir: begin
                    if (ir_code == btn_cam)
                        mode_next = mode_cam;
                    else if (ir_code == btn_idle)
                        mode_next = mode_idle;
                end
                default: mode_next = mode_idle;
            endcase
        end
    end

    // tracking looks at the mode being entered, not the current one
    always_comb begin
        if (mode_next != mode_cam) begin
            cam_next = cam_pause;
        end else begin
            case (cam_state)
                cam_pause:  cam_next = cam_search;
                cam_search: cam_next = orange ? cam_follow : cam_search;
                cam_follow: cam_next = orange ? cam_follow : cam_search;
                default:    cam_next = cam_pause;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            mode        <= mode_idle;
            cam_state   <= cam_pause;
            mode_change <= 1'b0;
        end else begin
            mode        <= mode_next;
            cam_state   <= cam_next;
            // one cycle pulse after any mode or sub-state move
            mode_change <= (mode_next != mode) || (cam_next != cam_state);
        end
    end

    a_mode_legal : assert property (
        @(posedge clk_50) disable iff (!rst_n)
        mode inside {mode_idle, mode_cam, mode_ir}
    );

    // a pulse needs a button strobe or live tracking at the edge before it
    a_change_backed : assert property (
        @(posedge clk_50) disable iff (!rst_n)
        mode_change |-> $past(ir_valid) || ($past(mode) == mode_cam)
    );

endmodule

//--- design/robot_pkg.sv
package robot_pkg;

    // IR remote button codes, one decoded byte per press
    localparam logic [7:0] btn_cam   = 8'h0f;
    localparam logic [7:0] btn_ir    = 8'h13;
    localparam logic [7:0] btn_idle  = 8'h10;
    localparam logic [7:0] btn_fwd   = 8'h18;
    localparam logic [7:0] btn_left  = 8'h08;
    localparam logic [7:0] btn_right = 8'h5a;
    localparam logic [7:0] btn_stop  = 8'h1c;

    // direction codes in the camera report
    localparam logic [2:0] cam_dir_left  = 3'd1;
    localparam logic [2:0] cam_dir_right = 3'd2;
    localparam logic [2:0] cam_dir_ahead = 3'd3;

    // pwm and hold timing, all in clk_50 cycles
    localparam int pwm_count_w = 6;
    localparam int hold_w      = 8;

    localparam logic [pwm_count_w-1:0] pwm_period  = 6'd50;
    localparam logic [pwm_count_w-1:0] duty_slow   = 6'd15;
    localparam logic [pwm_count_w-1:0] duty_medium = 6'd30;
    localparam logic [pwm_count_w-1:0] duty_fast   = 6'd50;
    localparam logic [pwm_count_w-1:0] duty_turn   = 6'd20;

    // lifetime of one manual command
    localparam logic [hold_w-1:0] hold_ticks = 8'd200;

    typedef enum logic [1:0] {
        mode_idle = 2'b00,
        mode_cam  = 2'b01,
        mode_ir   = 2'b10
    } mode_t;

    // tracking sub-state, only meaningful in camera mode
    typedef enum logic [1:0] {
        cam_search = 2'b00,
        cam_follow = 2'b01,
        cam_pause  = 2'b11
    } cam_state_t;

    typedef enum logic [2:0] {
        drive_stop   = 3'd0,
        drive_left   = 3'd1,
        drive_right  = 3'd2,
        drive_slow   = 3'd3,
        drive_medium = 3'd4,
        drive_fast   = 3'd5
    } drive_t;

    // camera report, speed 3 is invalid
    typedef struct packed {
        logic [2:0] direction;
        logic [1:0] speed;
        logic       orange;
    } sensor_t;

    // wheel outputs, fwd low means the wheel runs in reverse
    typedef struct packed {
        logic left_pwm;
        logic left_fwd;
        logic right_pwm;
        logic right_fwd;
    } motor_cmd_t;

endpackage
